//--- src/fpNormPkg.sv
/*
 * formats, register map and state encoding shared by the normalization bank
 * the intermediate mantissa has three whole bits followed by 26 fraction bits
 * a flag group is {inexact, underflow, overflow} with inexact in the msb
 */
package fpNormPkg;

	// --------------------------------------------------
	// number formats
	// --------------------------------------------------
	localparam int LANES = 4;
	localparam int EXP_W = 8;
	localparam logic [EXP_W-1:0] EXP_MAX = {EXP_W{1'b1}};
	// three whole bits and 26 fraction bits
	localparam int XMAN_W = 29;
	// one whole bit, 23 fraction bits, then guard, round and sticky
	localparam int NMAN_W = 27;
	localparam int FRAC_W = 23;
	localparam int ADR_W = 7;

	// --------------------------------------------------
	// register map, byte offsets
	// --------------------------------------------------
	// lane operands sit at a stride of 8 bytes
	localparam logic [ADR_W-1:0] LANE_HEAD = 7'h00;
	localparam logic [ADR_W-1:0] LANE_MAN = 7'h04;
	// packed results sit at a stride of 4 bytes
	localparam logic [ADR_W-1:0] RES_BASE = 7'h40;
	localparam logic [ADR_W-1:0] FLAGS = 7'h50;
	localparam logic [ADR_W-1:0] CTRL = 7'h54;

	// an underflowed exponent is read as two's complement
	typedef logic [EXP_W-1:0] fpExp_t;
	typedef logic [XMAN_W-1:0] fpXMan_t;
	typedef logic [NMAN_W-1:0] fpNMan_t;
	typedef logic [31:0] fpWord_t;
	typedef logic [2:0] fpFlags_t;

	// acknowledge machine of the bus slave
	typedef enum logic {IDLE, ACK} wbState_e;

endpackage

//--- src/fpNormWbRegs.sv
/*
 * Wishbone classic slave, single accesses only, no bursts and no wait states
 * every access takes two cycles and ack_o follows cyc_i and stb_i by one edge
 * a start written while a batch is in flight issues the next batch at once
 */
`timescale 1ns/1ns

module fpNormWbRegs (
	input  logic clk,
	input  logic arstN_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [fpNormPkg::ADR_W-1:0] adr_i,
	input  fpNormPkg::fpWord_t dat_i,
	output fpNormPkg::fpWord_t dat_o,
	output logic ack_o,
	output logic [fpNormPkg::LANES-1:0] laneValid_o,
	output logic [fpNormPkg::LANES-1:0] laneSign_o,
	output logic [fpNormPkg::LANES-1:0] laneUnder_o,
	output fpNormPkg::fpExp_t [fpNormPkg::LANES-1:0] laneExp_o,
	output fpNormPkg::fpXMan_t [fpNormPkg::LANES-1:0] laneMan_o,
	input  fpNormPkg::fpWord_t [fpNormPkg::LANES-1:0] resWord_i,
	input  fpNormPkg::fpFlags_t [fpNormPkg::LANES-1:0] resFlags_i,
	input  logic resDone_i
);

	fpNormPkg::wbState_e state;
	logic accept;
	logic wrEn;
	logic start;
	logic [fpNormPkg::LANES-1:0] headHit;
	logic [fpNormPkg::LANES-1:0] manHit;
	logic [fpNormPkg::LANES-1:0] resHit;
	logic flagsHit;
	logic ctrlHit;
	// number of batches issued whose results have not come back yet
	logic [1:0] inFlight;
	logic doneR;
	logic lastDone;
	logic busyBit;
	logic doneBit;
	fpNormPkg::fpWord_t rdData;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	always_comb begin
		headHit = '0;
		manHit = '0;
		resHit = '0;
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			// operand pairs are 8 bytes apart, results 4 bytes apart
			headHit[l] = adr_i == (fpNormPkg::LANE_HEAD + {l[3:0], 3'b000});
			manHit[l] = adr_i == (fpNormPkg::LANE_MAN + {l[3:0], 3'b000});
			resHit[l] = adr_i == (fpNormPkg::RES_BASE + {l[4:0], 2'b00});
		end
		flagsHit = adr_i == fpNormPkg::FLAGS;
		ctrlHit = adr_i == fpNormPkg::CTRL;
	end

	// a request is taken only while idle, so each access acks exactly once
	assign accept = (state == fpNormPkg::IDLE) && cyc_i && stb_i;
	assign wrEn = accept && we_i;
	assign start = wrEn && ctrlHit && dat_i[0];
	assign ack_o = state == fpNormPkg::ACK;

	// --------------------------------------------------
	// acknowledge machine and batch control
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			state <= fpNormPkg::IDLE;
			laneValid_o <= '0;
			inFlight <= 2'd0;
			doneR <= 1'b0;
		end else begin
			case (state)
				fpNormPkg::IDLE: if (cyc_i && stb_i) state <= fpNormPkg::ACK;
				default: state <= fpNormPkg::IDLE;
			endcase
			// every lane gets the same one-cycle issue pulse
			laneValid_o <= {fpNormPkg::LANES{start}};
			case ({start, resDone_i})
				2'b10: inFlight <= inFlight + 2'd1;
				2'b01: inFlight <= inFlight - 2'd1;
				default: inFlight <= inFlight;
			endcase
			if (start) begin
				doneR <= 1'b0;
			end else if (lastDone) begin
				doneR <= 1'b1;
			end
		end
	end

	// operand registers, one head and one mantissa word per lane
	always_ff @(posedge clk) begin
		if (wrEn) begin
			for (int l = 0; l < fpNormPkg::LANES; l++) begin
				if (headHit[l]) begin
					laneSign_o[l] <= dat_i[31];
					laneUnder_o[l] <= dat_i[30];
					laneExp_o[l] <= dat_i[fpNormPkg::EXP_W-1:0];
				end
				if (manHit[l]) begin
					laneMan_o[l] <= dat_i[fpNormPkg::XMAN_W-1:0];
				end
			end
		end
	end

	// --------------------------------------------------
	// read multiplexer
	// --------------------------------------------------
	// the returning pulse of the last batch already shows as done, so done
	// is readable in the same cycle that the results land
	assign lastDone = resDone_i && (inFlight == 2'd1);
	assign busyBit = (inFlight != 2'd0) && !lastDone;
	assign doneBit = doneR || lastDone;

	always_comb begin
		rdData = '0;
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			if (headHit[l]) rdData = {laneSign_o[l], laneUnder_o[l], 22'd0, laneExp_o[l]};
			if (manHit[l]) rdData = {3'd0, laneMan_o[l]};
			if (resHit[l]) rdData = resWord_i[l];
			// flag groups sit 4 bits apart with bit 3 of each group unused
			if (flagsHit) rdData[4*l +: 3] = resFlags_i[l];
		end
		if (ctrlHit) rdData = {30'd0, doneBit, busyBit};
	end

	// read data is only driven during the acknowledge cycle
	assign dat_o = ack_o ? rdData : '0;

	// the slave must not answer a master that has already left the cycle
	assert property (@(posedge clk) disable iff (!arstN_i) !cyc_i |=> !ack_o);

endmodule

//--- src/fpNormalize.sv
/*
 * two-cycle normalizer for one lane, one new item per clock
 * an underflowed exponent is two's complement and expected to stay at or
 * below zero after the whole-bit increment, otherwise no right shift occurs
 * overflow to infinity leaves a zero mantissa with inexact_o set
 */
`timescale 1ns/1ns

module fpNormalize (
	input  logic clk,
	input  logic arstN_i,
	input  logic valid_i,
	input  logic sign_i,
	input  logic under_i,
	input  fpNormPkg::fpExp_t exp_i,
	input  fpNormPkg::fpXMan_t man_i,
	output logic valid_o,
	output logic sign_o,
	output fpNormPkg::fpExp_t exp_o,
	output fpNormPkg::fpNMan_t man_o,
	output logic under_o,
	output logic inexact_o
);

	// stage 0, combinational from the inputs
	logic xInf0;
	logic incTwo0;
	logic incOne0;
	logic ovf0;
	logic [fpNormPkg::EXP_W:0] expSum0;
	fpNormPkg::fpExp_t exp0;
	fpNormPkg::fpNMan_t man0;
	logic inexact0;

	// stage 1 registers
	logic valid1;
	logic sign1;
	logic pass1;
	logic under1;
	fpNormPkg::fpExp_t exp1;
	fpNormPkg::fpNMan_t man1;
	logic inexact1;

	// stage 2, combinational shift logic
	fpNormPkg::fpExp_t lzc2;
	fpNormPkg::fpExp_t lShift2;
	fpNormPkg::fpExp_t rShift2;
	fpNormPkg::fpExp_t negExp2;
	fpNormPkg::fpExp_t expLeft2;
	fpNormPkg::fpNMan_t manLeft2;
	fpNormPkg::fpNMan_t manRight2;
	logic [2*fpNormPkg::NMAN_W-1:0] wide2;

	// --------------------------------------------------
	// whole-bit reduction
	// --------------------------------------------------
	always_comb begin
		// infinity and NaN keep their exponent and are never shifted
		xInf0 = (exp_i == fpNormPkg::EXP_MAX) && !under_i;
		incTwo0 = !xInf0 && man_i[28];
		incOne0 = !xInf0 && !man_i[28] && man_i[27];
		expSum0 = {1'b0, exp_i} + {{(fpNormPkg::EXP_W-1){1'b0}}, incTwo0, incOne0};
		// only a finite value that was not underflowed can run into infinity
		ovf0 = !under_i && !xInf0 && (expSum0 >= {1'b0, fpNormPkg::EXP_MAX});
		if (incTwo0) begin
			// shift right by two, the two lowest bits fold into sticky
			man0 = {man_i[28:3], |man_i[2:0]};
			inexact0 = |man_i[1:0];
		end else if (incOne0) begin
			man0 = {man_i[27:2], |man_i[1:0]};
			inexact0 = man_i[0];
		end else begin
			// the single whole bit already sits at bit 26
			man0 = man_i[fpNormPkg::NMAN_W-1:0];
			inexact0 = 1'b0;
		end
		exp0 = expSum0[fpNormPkg::EXP_W-1:0];
		if (ovf0) begin
			exp0 = fpNormPkg::EXP_MAX;
			man0 = '0;
			inexact0 = 1'b1;
		end
	end

	// --------------------------------------------------
	// stage 1 registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			valid1 <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid1 <= valid_i;
			valid_o <= valid1;
		end
	end

	always_ff @(posedge clk) begin
		sign1 <= sign_i;
		pass1 <= xInf0 || ovf0;
		under1 <= under_i;
		exp1 <= exp0;
		man1 <= man0;
		inexact1 <= inexact0;
	end

	// --------------------------------------------------
	// leading zeros and shift amounts
	// --------------------------------------------------
	always_comb begin : countZeros
		logic found;
		found = 1'b0;
		lzc2 = '0;
		for (int i = fpNormPkg::NMAN_W - 1; i >= 0; i--) begin
			if (!found) begin
				if (man1[i]) begin
					found = 1'b1;
				end else begin
					lzc2 = lzc2 + 8'd1;
				end
			end
		end
	end

	// left shift may not take the exponent below zero, the rest is a denormal
	assign lShift2 = (lzc2 > exp1) ? exp1 : lzc2;
	assign manLeft2 = man1 << lShift2;
	// a zero mantissa has nothing to normalize and becomes a true zero
	assign expLeft2 = (man1 == '0) ? '0 : exp1 - lShift2;

	// the underflowed exponent is negative, its negation is the right shift
	assign negExp2 = -exp1;
	always_comb begin
		if (!exp1[fpNormPkg::EXP_W-1]) begin
			rShift2 = '0;
		end else if (negExp2 > fpNormPkg::fpExp_t'(fpNormPkg::NMAN_W)) begin
			// beyond the full width every bit ends up in sticky
			rShift2 = fpNormPkg::fpExp_t'(fpNormPkg::NMAN_W);
		end else begin
			rShift2 = negExp2;
		end
	end

	// the lower half of the wide shift holds the bits that fall off
	assign wide2 = {man1, {fpNormPkg::NMAN_W{1'b0}}} >> rShift2;
	assign manRight2 = wide2[2*fpNormPkg::NMAN_W-1:fpNormPkg::NMAN_W]
		| {{(fpNormPkg::NMAN_W-1){1'b0}}, |wide2[fpNormPkg::NMAN_W-1:0]};

	// --------------------------------------------------
	// stage 2 registers, select the shifted result
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		sign_o <= sign1;
		inexact_o <= inexact1;
		under_o <= under1;
		if (pass1) begin
			exp_o <= exp1;
			man_o <= man1;
		end else if (under1) begin
			exp_o <= '0;
			man_o <= manRight2;
		end else begin
			exp_o <= expLeft2;
			man_o <= manLeft2;
		end
	end

	// a finite nonzero exponent leaves the pipe with its hidden bit in place
	assert property (@(posedge clk) disable iff (!arstN_i)
		valid_o && (exp_o != '0) && (exp_o != fpNormPkg::EXP_MAX) |-> man_o[fpNormPkg::NMAN_W-1]);

endmodule

//--- src/fpNormRoundPack.sv
/*
 * rounds every lane to nearest even and packs IEEE single precision words
 * an input at the all-ones exponent is passed on, with overflow raised only
 * when the normalizer marked it inexact
 */
`timescale 1ns/1ns

module fpNormRoundPack (
	input  logic clk,
	input  logic arstN_i,
	input  logic [fpNormPkg::LANES-1:0] valid_i,
	input  logic [fpNormPkg::LANES-1:0] sign_i,
	input  fpNormPkg::fpExp_t [fpNormPkg::LANES-1:0] exp_i,
	input  fpNormPkg::fpNMan_t [fpNormPkg::LANES-1:0] man_i,
	input  logic [fpNormPkg::LANES-1:0] under_i,
	input  logic [fpNormPkg::LANES-1:0] inexact_i,
	output fpNormPkg::fpWord_t [fpNormPkg::LANES-1:0] resWord_o,
	output fpNormPkg::fpFlags_t [fpNormPkg::LANES-1:0] resFlags_o,
	output logic resDone_o
);

	fpNormPkg::fpWord_t [fpNormPkg::LANES-1:0] wordN;
	fpNormPkg::fpFlags_t [fpNormPkg::LANES-1:0] flagsN;

	// --------------------------------------------------
	// round to nearest even and pack
	// --------------------------------------------------
	always_comb begin : roundLanes
		logic lsb;
		logic guard;
		logic rnd;
		logic sticky;
		logic roundUp;
		logic carry;
		logic inexact;
		logic [fpNormPkg::FRAC_W+1:0] sum;
		logic [fpNormPkg::EXP_W:0] expSum;
		logic [fpNormPkg::FRAC_W-1:0] frac;
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			lsb = man_i[l][3];
			guard = man_i[l][2];
			rnd = man_i[l][1];
			sticky = man_i[l][0];
			// ties go to the even neighbour
			roundUp = guard && (rnd || sticky || lsb);
			sum = {1'b0, man_i[l][fpNormPkg::NMAN_W-1:3]}
				+ {{(fpNormPkg::FRAC_W+1){1'b0}}, roundUp};
			// a denormal that rounds up into the hidden bit becomes the
			// smallest normal, which is also a step of the exponent
			carry = sum[fpNormPkg::FRAC_W+1]
				|| ((exp_i[l] == '0) && !man_i[l][fpNormPkg::NMAN_W-1] && sum[fpNormPkg::FRAC_W]);
			// a carry out of the mantissa leaves every fraction bit at zero
			frac = sum[fpNormPkg::FRAC_W-1:0];
			expSum = {1'b0, exp_i[l]} + {{fpNormPkg::EXP_W{1'b0}}, carry};
			inexact = inexact_i[l] || guard || rnd || sticky;
			if (exp_i[l] == fpNormPkg::EXP_MAX) begin
				// NaN payload bits survive, inexact here means a prior overflow
				wordN[l] = {sign_i[l], fpNormPkg::EXP_MAX, man_i[l][fpNormPkg::NMAN_W-2:3]};
				flagsN[l] = {inexact_i[l], 1'b0, inexact_i[l]};
			end else if (expSum >= {1'b0, fpNormPkg::EXP_MAX}) begin
				// the round carry pushed the value out of range
				wordN[l] = {sign_i[l], fpNormPkg::EXP_MAX, {fpNormPkg::FRAC_W{1'b0}}};
				flagsN[l] = 3'b101;
			end else begin
				wordN[l] = {sign_i[l], expSum[fpNormPkg::EXP_W-1:0], frac};
				flagsN[l] = {inexact, under_i[l] && inexact, 1'b0};
			end
		end
	end

	// --------------------------------------------------
	// result registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			resWord_o <= '0;
			resFlags_o <= '0;
			resDone_o <= 1'b0;
		end else begin
			for (int l = 0; l < fpNormPkg::LANES; l++) begin
				if (valid_i[l]) begin
					resWord_o[l] <= wordN[l];
					resFlags_o[l] <= flagsN[l];
				end
			end
			// lanes travel in lockstep, so one pulse covers the whole batch
			resDone_o <= &valid_i;
		end
	end

	// every lane is issued on the same edge and has the same latency
	assert property (@(posedge clk) disable iff (!arstN_i)
		(valid_i == '0) || (&valid_i));

endmodule

//--- src/fpNormArray.sv
/*
 * four-lane normalization bank behind a Wishbone classic slave
 * results of a batch are readable three clocks after the start is acknowledged
 */
`timescale 1ns/1ns

module fpNormArray (
	input  logic clk,
	input  logic arstN_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [fpNormPkg::ADR_W-1:0] adr_i,
	input  fpNormPkg::fpWord_t dat_i,
	output fpNormPkg::fpWord_t dat_o,
	output logic ack_o
);

	// --------------------------------------------------
	// issue side, operand registers to the lanes
	// --------------------------------------------------
	logic [fpNormPkg::LANES-1:0] laneValid;
	logic [fpNormPkg::LANES-1:0] laneSign;
	logic [fpNormPkg::LANES-1:0] laneUnder;
	fpNormPkg::fpExp_t [fpNormPkg::LANES-1:0] laneExp;
	fpNormPkg::fpXMan_t [fpNormPkg::LANES-1:0] laneMan;

	// normalized lanes into the rounding block
	logic [fpNormPkg::LANES-1:0] nValid;
	logic [fpNormPkg::LANES-1:0] nSign;
	fpNormPkg::fpExp_t [fpNormPkg::LANES-1:0] nExp;
	fpNormPkg::fpNMan_t [fpNormPkg::LANES-1:0] nMan;
	logic [fpNormPkg::LANES-1:0] nUnder;
	logic [fpNormPkg::LANES-1:0] nInexact;

	// packed results back to the slave
	fpNormPkg::fpWord_t [fpNormPkg::LANES-1:0] resWord;
	fpNormPkg::fpFlags_t [fpNormPkg::LANES-1:0] resFlags;
	logic resDone;

	fpNormWbRegs uRegs (
		.clk(clk),
		.arstN_i(arstN_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.dat_o(dat_o),
		.ack_o(ack_o),
		.laneValid_o(laneValid),
		.laneSign_o(laneSign),
		.laneUnder_o(laneUnder),
		.laneExp_o(laneExp),
		.laneMan_o(laneMan),
		.resWord_i(resWord),
		.resFlags_i(resFlags),
		.resDone_i(resDone)
	);

	// one normalizer per lane, all running in lockstep
	genvar g;
	generate
		for (g = 0; g < fpNormPkg::LANES; g++) begin : gLane
			fpNormalize uNorm (
				.clk(clk),
				.arstN_i(arstN_i),
				.valid_i(laneValid[g]),
				.sign_i(laneSign[g]),
				.under_i(laneUnder[g]),
				.exp_i(laneExp[g]),
				.man_i(laneMan[g]),
				.valid_o(nValid[g]),
				.sign_o(nSign[g]),
				.exp_o(nExp[g]),
				.man_o(nMan[g]),
				.under_o(nUnder[g]),
				.inexact_o(nInexact[g])
			);
		end
	endgenerate

	fpNormRoundPack uRound (
		.clk(clk),
		.arstN_i(arstN_i),
		.valid_i(nValid),
		.sign_i(nSign),
		.exp_i(nExp),
		.man_i(nMan),
		.under_i(nUnder),
		.inexact_i(nInexact),
		.resWord_o(resWord),
		.resFlags_o(resFlags),
		.resDone_o(resDone)
	);

endmodule

//--- test/tbFpNormArray.sv
/*
 * directed tests for the normalization bank, driven through its Wishbone port
 * expected words and flags come from a model of the normalization rules
 * underflowed exponents stay between -31 and 0, so the model never sees a wrap
 */
`timescale 1ns/1ns

module tbFpNormArray;

	logic clk;
	logic arstN;
	logic cyc;
	logic stb;
	logic we;
	logic [fpNormPkg::ADR_W-1:0] adr;
	fpNormPkg::fpWord_t datIn;
	fpNormPkg::fpWord_t datOut;
	logic ack;

	int errors;
	int checks;
	int cycles;
	int testStart;
	logic [31:0] lfsr;

	// operands of the batch that is loaded next
	logic laneS [fpNormPkg::LANES];
	logic laneU [fpNormPkg::LANES];
	fpNormPkg::fpExp_t laneE [fpNormPkg::LANES];
	fpNormPkg::fpXMan_t laneM [fpNormPkg::LANES];

	fpNormArray uut (
		.clk(clk),
		.arstN_i(arstN),
		.cyc_i(cyc),
		.stb_i(stb),
		.we_i(we),
		.adr_i(adr),
		.dat_i(datIn),
		.dat_o(datOut),
		.ack_o(ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// each test restarts the count, the longest one needs a few hundred cycles
	initial begin : watchdog
		cycles = 0;
		while (cycles - testStart < 2000) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after 2000 cycles in one test because done never arrived");
		$display("Test FAILED");
		$finish;
	end

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	// Galois form of x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checks++;
		if (expVal !== actVal) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic startTest(input string name);
		testStart = cycles;
		$display("running %s", name);
	endtask

	// the request is already on the bus, wait for the single ack cycle
	task automatic awaitAck(input logic [fpNormPkg::ADR_W-1:0] a);
		int waitCnt;
		waitCnt = 0;
		@(posedge clk);
		#1;
		while (!ack && waitCnt < 8) begin
			@(posedge clk);
			#1;
			waitCnt++;
		end
		if (!ack) begin
			errors++;
			$display("the slave never acknowledged the access to address %h", a);
		end
	endtask

	task automatic wbWrite(input logic [fpNormPkg::ADR_W-1:0] a, input fpNormPkg::fpWord_t d);
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datIn = d;
		awaitAck(a);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	// read data is sampled one ns into the ack cycle, where it is stable
	task automatic wbRead(input logic [fpNormPkg::ADR_W-1:0] a, output fpNormPkg::fpWord_t d);
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		awaitAck(a);
		d = datOut;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic expectRead(input logic [fpNormPkg::ADR_W-1:0] a, input string name,
		input logic [31:0] expVal);
		fpNormPkg::fpWord_t rd;
		wbRead(a, rd);
		compareValue(name, expVal, rd);
	endtask

	// --------------------------------------------------
	// reference model, returns {flags, packed word}
	// --------------------------------------------------
	function automatic logic [34:0] normRef(input logic s, input logic u,
		input fpNormPkg::fpExp_t e8, input fpNormPkg::fpXMan_t m29);
		int e;
		int inc;
		int sh;
		int lz;
		logic [26:0] m;
		logic [53:0] wide;
		logic inx;
		logic up;
		logic [24:0] rnd;
		logic [22:0] frac;
		// infinity and NaN keep their fraction bits and raise nothing
		if (!u && e8 == 8'hff) begin
			return {3'b000, s, 8'hff, m29[25:3]};
		end
		// three whole bits down to one, dropped bits fold into sticky
		inc = m29[28] ? 2 : (m29[27] ? 1 : 0);
		m = 27'(m29 >> inc);
		inx = (inc == 2) ? |m29[1:0] : ((inc == 1) ? m29[0] : 1'b0);
		m[0] = m[0] | inx;
		e = u ? int'($signed(e8)) : int'(e8);
		e = e + inc;
		if (!u && e >= 255) begin
			return {3'b101, s, 8'hff, 23'd0};
		end
		if (u) begin
			// a negative exponent is the distance to shift right
			sh = (e < 0) ? -e : 0;
			if (sh > 27) sh = 27;
			wide = {m, 27'd0} >> sh;
			m = wide[53:27];
			m[0] = m[0] | (|wide[26:0]);
			e = 0;
		end else begin
			lz = 0;
			while (lz < 27 && !m[26 - lz]) lz++;
			// the left shift stops at exponent zero, which leaves a denormal
			sh = (lz < e) ? lz : e;
			m = m << sh;
			e = (m == '0) ? 0 : e - sh;
		end
		// nearest even on guard, round and sticky
		inx = inx | (|m[2:0]);
		up = m[2] && (m[1] || m[0] || m[3]);
		rnd = {1'b0, m[26:3]} + 25'(up);
		frac = rnd[22:0];
		if (rnd[24]) begin
			e = e + 1;
			frac = '0;
		end else if (e == 0 && !m[26] && rnd[23]) begin
			// a denormal rounding into the hidden bit is the smallest normal
			e = 1;
		end
		if (e >= 255) begin
			return {3'b101, s, 8'hff, 23'd0};
		end
		return {inx, u && inx, 1'b0, s, 8'(e), frac};
	endfunction

	// --------------------------------------------------
	// batch handling
	// --------------------------------------------------
	task automatic setLane(input int l, input logic s, input logic u,
		input fpNormPkg::fpExp_t e, input fpNormPkg::fpXMan_t m);
		laneS[l] = s;
		laneU[l] = u;
		laneE[l] = e;
		laneM[l] = m;
	endtask

	task automatic randomLanes();
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			laneS[l] = 1'(randBits(1));
			laneU[l] = randBits(3) == 32'd0;
			laneE[l] = laneU[l] ? 8'(32'd0 - randBits(5)) : 8'(randBits(8));
			// a random right shift gives a spread of leading zeros
			laneM[l] = 29'(randBits(29) >> (2 * randBits(4)));
		end
	endtask

	task automatic loadLanes();
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			wbWrite(7'(fpNormPkg::LANE_HEAD + 8 * l), {laneS[l], laneU[l], 22'd0, laneE[l]});
			wbWrite(7'(fpNormPkg::LANE_MAN + 8 * l), {3'd0, laneM[l]});
		end
	endtask

	// polls CTRL until done, then busy must already be clear
	task automatic waitDone();
		fpNormPkg::fpWord_t st;
		st = '0;
		while (!st[1]) wbRead(fpNormPkg::CTRL, st);
		compareValue("CTRL after done", 32'h2, st);
	endtask

	task automatic checkResults(input string tag);
		fpNormPkg::fpWord_t rd;
		logic [34:0] model;
		logic [31:0] expFlags;
		expFlags = '0;
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			model = normRef(laneS[l], laneU[l], laneE[l], laneM[l]);
			wbRead(7'(fpNormPkg::RES_BASE + 4 * l), rd);
			compareValue($sformatf("%s result lane %0d", tag, l), model[31:0], rd);
			expFlags = expFlags | (32'(model[34:32]) << (4 * l));
		end
		wbRead(fpNormPkg::FLAGS, rd);
		compareValue({tag, " FLAGS"}, expFlags, rd);
	endtask

	task automatic runBatch(input string tag);
		loadLanes();
		wbWrite(fpNormPkg::CTRL, 32'd1);
		waitDone();
		checkResults(tag);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic testRegs();
		fpNormPkg::fpWord_t head [fpNormPkg::LANES];
		fpNormPkg::fpWord_t man [fpNormPkg::LANES];
		startTest("register access");
		expectRead(fpNormPkg::CTRL, "CTRL after reset", 32'h0);
		expectRead(fpNormPkg::FLAGS, "FLAGS after reset", 32'h0);
		expectRead(fpNormPkg::RES_BASE, "result lane 0 after reset", 32'h0);
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			head[l] = randBits(32) & 32'hc000_00ff;
			man[l] = randBits(32) & 32'h1fff_ffff;
			wbWrite(7'(fpNormPkg::LANE_HEAD + 8 * l), head[l]);
			wbWrite(7'(fpNormPkg::LANE_MAN + 8 * l), man[l]);
		end
		for (int l = 0; l < fpNormPkg::LANES; l++) begin
			expectRead(7'(fpNormPkg::LANE_HEAD + 8 * l), $sformatf("head lane %0d", l), head[l]);
			expectRead(7'(fpNormPkg::LANE_MAN + 8 * l), $sformatf("mantissa lane %0d", l), man[l]);
		end
	endtask

	task automatic testExact();
		startTest("exact normal values");
		// 1.0, 2.0, 3.0 and -4.0 at a biased exponent of 127
		setLane(0, 1'b0, 1'b0, 8'd127, 29'h0400_0000);
		setLane(1, 1'b0, 1'b0, 8'd127, 29'h0800_0000);
		setLane(2, 1'b0, 1'b0, 8'd127, 29'h0c00_0000);
		setLane(3, 1'b1, 1'b0, 8'd127, 29'h1000_0000);
		runBatch("exact");
		expectRead(7'(fpNormPkg::RES_BASE + 0), "exact 1.0", 32'h3f80_0000);
		expectRead(7'(fpNormPkg::RES_BASE + 4), "exact 2.0", 32'h4000_0000);
		expectRead(7'(fpNormPkg::RES_BASE + 8), "exact 3.0", 32'h4040_0000);
		expectRead(7'(fpNormPkg::RES_BASE + 12), "exact -4.0", 32'hc080_0000);
		expectRead(fpNormPkg::FLAGS, "exact FLAGS", 32'h0);
	endtask

	task automatic testLeftShift();
		startTest("left normalization and denormals");
		setLane(0, 1'b0, 1'b0, 8'd100, 29'h0000_0400);
		// only five steps of exponent are left, so the result stays denormal
		setLane(1, 1'b0, 1'b0, 8'd5, 29'h0000_0020);
		setLane(2, 1'b1, 1'b0, 8'd20, 29'h0012_3457);
		setLane(3, 1'b0, 1'b0, 8'd50, 29'h0000_0000);
		runBatch("left shift");
		expectRead(7'(fpNormPkg::RES_BASE + 0), "left shift lane 0", 32'h2a00_0000);
		expectRead(7'(fpNormPkg::RES_BASE + 4), "denormal lane 1", 32'h0000_0080);
		expectRead(7'(fpNormPkg::RES_BASE + 12), "zero lane 3", 32'h0000_0000);
	endtask

	task automatic testUnderflow();
		startTest("underflowed inputs");
		setLane(0, 1'b0, 1'b1, 8'hfd, 29'h0400_0005);
		// thirty places pushes every bit into sticky
		setLane(1, 1'b1, 1'b1, 8'he2, 29'h0555_5555);
		setLane(2, 1'b0, 1'b1, 8'hfc, 29'h1000_0007);
		// rounds up into the hidden bit and becomes the smallest normal
		setLane(3, 1'b0, 1'b1, 8'hff, 29'h07ff_ffff);
		runBatch("underflow");
		expectRead(7'(fpNormPkg::RES_BASE + 12), "underflow lane 3", 32'h0080_0000);
	endtask

	task automatic testSpecial();
		startTest("infinity, NaN and overflow");
		setLane(0, 1'b0, 1'b0, 8'hff, 29'h0000_0000);
		setLane(1, 1'b1, 1'b0, 8'hff, 29'h0123_4568);
		setLane(2, 1'b0, 1'b0, 8'hfe, 29'h1000_0000);
		// every fraction bit set plus guard, the round carry overflows
		setLane(3, 1'b0, 1'b0, 8'hfe, 29'h07ff_ffff);
		runBatch("special");
		expectRead(7'(fpNormPkg::RES_BASE + 0), "infinity lane 0", 32'h7f80_0000);
		expectRead(7'(fpNormPkg::RES_BASE + 8), "overflow lane 2", 32'h7f80_0000);
		expectRead(7'(fpNormPkg::RES_BASE + 12), "round overflow lane 3", 32'h7f80_0000);
		expectRead(fpNormPkg::FLAGS, "special FLAGS", 32'h0000_5500);
	endtask

	task automatic testRandom();
		startTest("random lanes");
		for (int b = 0; b < 10; b++) begin
			randomLanes();
			runBatch($sformatf("random batch %0d", b));
		end
	endtask

	// the second start lands while the first batch is still in the pipe
	task automatic testBackToBack();
		fpNormPkg::fpWord_t rd;
		startTest("back to back starts");
		randomLanes();
		loadLanes();
		wbWrite(fpNormPkg::CTRL, 32'd1);
		wbWrite(fpNormPkg::CTRL, 32'd1);
		wbRead(fpNormPkg::CTRL, rd);
		compareValue("CTRL while the second batch runs", 32'h1, rd);
		waitDone();
		checkResults("back to back");
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		lfsr = 32'h11a9_294d;
		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;
		testRegs();
		testExact();
		testLeftShift();
		testUnderflow();
		testSpecial();
		testRandom();
		testBackToBack();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
src/fpNormPkg.sv
src/fpNormWbRegs.sv
src/fpNormalize.sv
src/fpNormRoundPack.sv
src/fpNormArray.sv
test/tbFpNormArray.sv

//--- Makefile
# Verilator build and run of the normalization bank testbench
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
TOP       := tbFpNormArray
FLIST     := flist.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
